// File: all.f
rtl/smem_pkg.sv
rtl/read_loader.sv
rtl/extension_queue.sv
rtl/forward_extend.sv
rtl/result_buffer.sv
rtl/smem_top.sv
verification/smem_asserts.sv
verification/smem_tb.sv

// File: rtl/extension_queue.sv
`timescale 1ns/10ps

module extension_queue #(
	parameter int QUEUE_DEPTH = smem_pkg::QUEUE_DEPTH
) (
	input  logic                               clk_32ui_i,
	input  logic                               reset_i,
	input  logic                               push_i,
	input  smem_pkg::context_t                 push_ctx_i,
	input  logic                               pop_i,
	output smem_pkg::context_t                 head_ctx_o,
	output logic [$clog2(QUEUE_DEPTH+1)-1:0]   count_o
);
	import smem_pkg::*;

	localparam int PTR_W = $clog2(QUEUE_DEPTH);

	context_t          ctx_mem [QUEUE_DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;

	// wraps for depths that are not a power of two
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(QUEUE_DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	// ----------------------------------------
	// pointers and occupancy
	// ----------------------------------------
	always_ff @(posedge clk_32ui_i) begin
		if (reset_i) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count_o <= '0;
		end else begin
			if (push_i)
				wr_ptr <= ptr_next(wr_ptr);
			if (pop_i)
				rd_ptr <= ptr_next(rd_ptr);
			case ({push_i, pop_i})
				2'b10:   count_o <= count_o + 1'b1;
				2'b01:   count_o <= count_o - 1'b1;
				default: count_o <= count_o; // both or neither
			endcase
		end
	end

	always_ff @(posedge clk_32ui_i) begin
		if (push_i)
			ctx_mem[wr_ptr] <= push_ctx_i;
	end

	// oldest request sits at the head, matching in-order responses
	assign head_ctx_o = ctx_mem[rd_ptr];

endmodule

// File: rtl/forward_extend.sv
`timescale 1ns/10ps

module forward_extend #(
	parameter int QUEUE_DEPTH = smem_pkg::QUEUE_DEPTH
) (
	input  logic                                  clk_32ui_i,
	input  logic                                  reset_i,
	input  logic                                  DRAM_get_i,
	input  smem_pkg::occ_counts_t                 cnt_k_i,
	input  smem_pkg::occ_counts_t                 cnt_l_i,
	input  smem_pkg::context_t                    head_ctx_i,
	input  logic [$clog2(QUEUE_DEPTH+1)-1:0]      queue_count_i,
	output logic                                  pop_o,
	output logic                                  push_o,
	output smem_pkg::context_t                    push_ctx_o,
	input  logic                                  new_read_valid_i,
	input  smem_pkg::context_t                    new_ctx_i,
	output logic                                  new_read_o,
	output logic [smem_pkg::READ_NUM_WIDTH-1:0]   lookup_read_num_o,
	output logic [smem_pkg::POS_WIDTH-1:0]        lookup_pos_o,
	input  smem_pkg::base_t                       lookup_base_i,
	input  logic [smem_pkg::POS_WIDTH-1:0]        lookup_len_i,
	input  logic [3:0][smem_pkg::IV_WIDTH-1:0]    c_table_i,
	output logic                                  DRAM_valid_o,
	output logic [smem_pkg::IV_WIDTH-1:0]         addr_k_o,
	output logic [smem_pkg::IV_WIDTH-1:0]         addr_l_o,
	output logic [smem_pkg::READ_NUM_WIDTH-1:0]   DRAM_read_num_o,
	output logic                                  result_valid_o,
	output smem_pkg::result_t                     result_o
);
	import smem_pkg::*;

	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	logic [IV_WIDTH-1:0]   new_k;
	logic [IV_WIDTH-1:0]   new_l;
	logic [POS_WIDTH-1:0]  new_pos;

	logic                  s1_valid;  // registered response
	logic                  s1_finish;
	context_t              s1_ctx;    // pos holds match_len when finishing

	logic                  recirc;
	logic                  admit;
	context_t              issue_ctx;

	// ----------------------------------------
	// response stage
	// ----------------------------------------
	assign pop_o             = DRAM_get_i;
	assign lookup_read_num_o = head_ctx_i.read_num;
	assign lookup_pos_o      = head_ctx_i.pos;

	assign new_k   = c_table_i[lookup_base_i] + occ_pick(cnt_k_i, lookup_base_i);
	assign new_l   = c_table_i[lookup_base_i] + occ_pick(cnt_l_i, lookup_base_i);
	assign new_pos = head_ctx_i.pos + 1'b1;

	always_ff @(posedge clk_32ui_i) begin
		if (reset_i)
			s1_valid <= 1'b0;
		else
			s1_valid <= DRAM_get_i;
	end

	always_ff @(posedge clk_32ui_i) begin
		if (DRAM_get_i) begin
			s1_ctx.read_num <= head_ctx_i.read_num;
			if (new_l <= new_k) begin
				// empty interval keeps the old match
				s1_finish  <= 1'b1;
				s1_ctx.pos <= head_ctx_i.pos;
				s1_ctx.k   <= head_ctx_i.k;
				s1_ctx.l   <= head_ctx_i.l;
			end else begin
				s1_finish  <= (new_pos == lookup_len_i); // whole read matched
				s1_ctx.pos <= new_pos;
				s1_ctx.k   <= new_k;
				s1_ctx.l   <= new_l;
			end
		end
	end

	// ----------------------------------------
	// issue stage
	// ----------------------------------------
	// recirculation first, new read only with a spare slot
	assign recirc    = s1_valid && !s1_finish;
	assign admit     = !recirc && new_read_valid_i && (queue_count_i < CNT_W'(QUEUE_DEPTH - 1));
	assign issue_ctx = recirc ? s1_ctx : new_ctx_i;

	assign push_o     = recirc || admit;
	assign push_ctx_o = issue_ctx;
	assign new_read_o = admit;

	always_ff @(posedge clk_32ui_i) begin
		if (reset_i) begin
			DRAM_valid_o   <= 1'b0;
			result_valid_o <= 1'b0;
		end else begin
			DRAM_valid_o   <= push_o;
			result_valid_o <= s1_valid && s1_finish;
		end
	end

	always_ff @(posedge clk_32ui_i) begin
		addr_k_o        <= issue_ctx.k;
		addr_l_o        <= issue_ctx.l;
		DRAM_read_num_o <= issue_ctx.read_num;
		result_o        <= '{
			read_num:  s1_ctx.read_num,
			match_len: s1_ctx.pos,
			k:         s1_ctx.k,
			l:         s1_ctx.l
		};
	end

endmodule

// File: rtl/read_loader.sv
`timescale 1ns/10ps

module read_loader (
	input  logic                                            clk_32ui_i,
	input  logic                                            reset_i,
	input  logic                                            load_valid_i,
	input  smem_pkg::load_line_t                            load_data_i,
	input  logic [smem_pkg::POS_WIDTH-1:0]                  batch_size_i,
	output logic                                            load_done_o,
	input  logic                                            new_read_i,
	output logic                                            new_read_valid_o,
	output smem_pkg::context_t                              new_ctx_o,
	input  logic [smem_pkg::READ_NUM_WIDTH-1:0]             lookup_read_num_i,
	input  logic [smem_pkg::POS_WIDTH-1:0]                  lookup_pos_i,
	output smem_pkg::base_t                                 lookup_base_o,
	output logic [smem_pkg::POS_WIDTH-1:0]                  lookup_len_o,
	output logic [3:0][smem_pkg::IV_WIDTH-1:0]              c_table_o
);
	import smem_pkg::*;

	localparam int BASE_IDX_W = $clog2(MAX_BASES);

	logic                      param_loaded; // first line of batch seen
	logic [POS_WIDTH-1:0]      line_cnt;     // read lines taken
	logic [POS_WIDTH-1:0]      issue_cnt;    // reads handed to the pipeline
	logic [IV_WIDTH-1:0]       seq_len;
	logic                      take_line;

	logic [POS_WIDTH-1:0]      len_mem   [MAX_READ];
	base_t [MAX_BASES-1:0]     bases_mem [MAX_READ];

	assign take_line = load_valid_i && !load_done_o;

	// ----------------------------------------
	// batch loading
	// ----------------------------------------
	always_ff @(posedge clk_32ui_i) begin
		if (reset_i) begin
			param_loaded <= 1'b0;
			line_cnt     <= '0;
			load_done_o  <= 1'b0;
		end else if (take_line) begin
			if (!param_loaded) begin
				param_loaded <= 1'b1;
			end else begin
				line_cnt <= line_cnt + 1'b1;
				if (line_cnt + 1'b1 == batch_size_i)
					load_done_o <= 1'b1; // last read line
			end
		end
	end

	always_ff @(posedge clk_32ui_i) begin
		if (take_line) begin
			if (!param_loaded) begin
				c_table_o <= load_data_i.param.line.c_table;
				seq_len   <= load_data_i.param.line.seq_len;
			end else begin
				len_mem[line_cnt[READ_NUM_WIDTH-1:0]]   <= load_data_i.rd.line.len;
				bases_mem[line_cnt[READ_NUM_WIDTH-1:0]] <= load_data_i.rd.line.bases;
			end
		end
	end

	// ----------------------------------------
	// new reads
	// ----------------------------------------
	always_ff @(posedge clk_32ui_i) begin
		if (reset_i)
			issue_cnt <= '0;
		else if (new_read_i && new_read_valid_o)
			issue_cnt <= issue_cnt + 1'b1;
	end

	assign new_read_valid_o = load_done_o && (issue_cnt < batch_size_i);

	// a fresh read starts from the whole text
	assign new_ctx_o = '{
		read_num: issue_cnt[READ_NUM_WIDTH-1:0],
		pos:      '0,
		k:        '0,
		l:        seq_len
	};

	// combinational lookup for the extension stage
	assign lookup_base_o = bases_mem[lookup_read_num_i][lookup_pos_i[BASE_IDX_W-1:0]];
	assign lookup_len_o  = len_mem[lookup_read_num_i];

endmodule

// File: rtl/result_buffer.sv
`timescale 1ns/10ps

module result_buffer (
	input  logic                              clk_32ui_i,
	input  logic                              reset_i,
	input  logic [smem_pkg::POS_WIDTH-1:0]    batch_size_i,
	input  logic                              result_valid_i,
	input  smem_pkg::result_t                 result_i,
	output logic                              output_request_o,
	input  logic                              output_permit_i,
	output logic [smem_pkg::CL-1:0]           output_data_o,
	output logic                              output_valid_o,
	output logic                              output_finish_o
);
	import smem_pkg::*;

	localparam int PAD_W = CL - $bits(result_t);

	result_t                   res_mem [MAX_READ];
	logic [READ_NUM_WIDTH-1:0] wr_ptr;  // wraps at MAX_READ
	logic [READ_NUM_WIDTH-1:0] rd_ptr;
	logic [READ_NUM_WIDTH:0]   count;
	logic [POS_WIDTH-1:0]      out_cnt; // lines sent so far
	logic                      emit;

	assign output_request_o = (count != '0);
	assign emit             = output_permit_i && output_request_o;

	// ----------------------------------------
	// result FIFO
	// ----------------------------------------
	always_ff @(posedge clk_32ui_i) begin
		if (reset_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (result_valid_i)
				wr_ptr <= wr_ptr + 1'b1;
			if (emit)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + result_valid_i - emit;
		end
	end

	always_ff @(posedge clk_32ui_i) begin
		if (result_valid_i)
			res_mem[wr_ptr] <= result_i;
		if (emit)
			output_data_o <= {{PAD_W{1'b0}}, res_mem[rd_ptr]};
	end

	// ----------------------------------------
	// output port and finish
	// ----------------------------------------
	always_ff @(posedge clk_32ui_i) begin
		if (reset_i) begin
			output_valid_o  <= 1'b0;
			output_finish_o <= 1'b0;
			out_cnt         <= '0;
		end else begin
			output_valid_o <= emit; // one cycle after the permit
			if (output_valid_o) begin
				out_cnt <= out_cnt + 1'b1;
				if (out_cnt + 1'b1 == batch_size_i)
					output_finish_o <= 1'b1;
			end
		end
	end

endmodule

// File: rtl/smem_pkg.sv
package smem_pkg;

	// ----------------------------------------
	// widths and sizes
	// ----------------------------------------
	localparam int CL             = 512; // cache line
	localparam int READ_NUM_WIDTH = 6;
	localparam int MAX_READ       = 64;
	localparam int POS_WIDTH      = 7;   // holds 0..64
	localparam int MAX_BASES      = 64;
	localparam int IV_WIDTH       = 32;  // interval bound
	localparam int QUEUE_DEPTH    = 8;   // default in-flight contexts

	// 0 = A, 1 = C, 2 = G, 3 = T
	typedef logic [1:0] base_t;

	// per-base occurrence counts returned by memory
	typedef struct packed {
		logic [IV_WIDTH-1:0] t;
		logic [IV_WIDTH-1:0] g;
		logic [IV_WIDTH-1:0] c;
		logic [IV_WIDTH-1:0] a;
	} occ_counts_t;

	// ----------------------------------------
	// load lines
	// ----------------------------------------
	typedef struct packed {
		logic [IV_WIDTH-1:0]            seq_len;
		logic [3:0][IV_WIDTH-1:0]       c_table; // indexed by base
	} param_line_t;

	typedef struct packed {
		logic [POS_WIDTH-1:0]           len;
		base_t [MAX_BASES-1:0]          bases;   // bases[0] is first
	} read_line_t;

	// first line of a batch is parameters, the rest are reads
	typedef union packed {
		struct packed {
			logic [CL-$bits(param_line_t)-1:0] pad;
			param_line_t                       line;
		} param;
		struct packed {
			logic [CL-$bits(read_line_t)-1:0]  pad;
			read_line_t                        line;
		} rd;
	} load_line_t;

	// ----------------------------------------
	// in-flight and finished reads
	// ----------------------------------------
	typedef struct packed {
		logic [READ_NUM_WIDTH-1:0] read_num;
		logic [POS_WIDTH-1:0]      pos;
		logic [IV_WIDTH-1:0]       k;
		logic [IV_WIDTH-1:0]       l;
	} context_t;

	typedef struct packed {
		logic [READ_NUM_WIDTH-1:0] read_num;
		logic [POS_WIDTH-1:0]      match_len;
		logic [IV_WIDTH-1:0]       k;
		logic [IV_WIDTH-1:0]       l;
	} result_t;

	// count for one base out of a response
	function automatic logic [IV_WIDTH-1:0] occ_pick(input occ_counts_t occ, input base_t b);
		case (b)
			2'd0: return occ.a;
			2'd1: return occ.c;
			2'd2: return occ.g;
			default: return occ.t;
		endcase
	endfunction

endpackage

// File: rtl/smem_top.sv
`timescale 1ns/10ps

module smem_top #(
	parameter int QUEUE_DEPTH = smem_pkg::QUEUE_DEPTH
) (
	input  logic                                  clk_32ui_i,
	input  logic                                  reset_i,
	input  logic                                  load_valid_i,
	input  smem_pkg::load_line_t                  load_data_i,
	input  logic [smem_pkg::POS_WIDTH-1:0]        batch_size_i,
	output logic                                  read_load_done_o,
	output logic                                  DRAM_valid_o,
	output logic [smem_pkg::IV_WIDTH-1:0]         addr_k_o,
	output logic [smem_pkg::IV_WIDTH-1:0]         addr_l_o,
	output logic [smem_pkg::READ_NUM_WIDTH-1:0]   DRAM_read_num_o,
	input  logic                                  DRAM_get_i,
	input  smem_pkg::occ_counts_t                 cnt_k_i,
	input  smem_pkg::occ_counts_t                 cnt_l_i,
	output logic                                  output_request_o,
	input  logic                                  output_permit_i,
	output logic [smem_pkg::CL-1:0]               output_data_o,
	output logic                                  output_valid_o,
	output logic                                  output_finish_o
);
	import smem_pkg::*;

	// loader <-> extension
	logic                          new_read;
	logic                          new_read_valid;
	context_t                      new_ctx;
	logic [READ_NUM_WIDTH-1:0]     lookup_read_num;
	logic [POS_WIDTH-1:0]          lookup_pos;
	base_t                         lookup_base;
	logic [POS_WIDTH-1:0]          lookup_len;
	logic [3:0][IV_WIDTH-1:0]      c_table;

	// extension <-> queue
	logic                          push;
	logic                          pop;
	context_t                      push_ctx;
	context_t                      head_ctx;
	logic [$clog2(QUEUE_DEPTH+1)-1:0] queue_count;

	// extension -> results
	logic                          result_valid;
	result_t                       result;

	read_loader read_loader_i (
		.clk_32ui_i        (clk_32ui_i),
		.reset_i           (reset_i),
		.load_valid_i      (load_valid_i),
		.load_data_i       (load_data_i),
		.batch_size_i      (batch_size_i),
		.load_done_o       (read_load_done_o),
		.new_read_i        (new_read),
		.new_read_valid_o  (new_read_valid),
		.new_ctx_o         (new_ctx),
		.lookup_read_num_i (lookup_read_num),
		.lookup_pos_i      (lookup_pos),
		.lookup_base_o     (lookup_base),
		.lookup_len_o      (lookup_len),
		.c_table_o         (c_table)
	);

	extension_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) extension_queue_i (
		.clk_32ui_i (clk_32ui_i),
		.reset_i    (reset_i),
		.push_i     (push),
		.push_ctx_i (push_ctx),
		.pop_i      (pop),
		.head_ctx_o (head_ctx),
		.count_o    (queue_count)
	);

	forward_extend #(.QUEUE_DEPTH(QUEUE_DEPTH)) forward_extend_i (
		.clk_32ui_i        (clk_32ui_i),
		.reset_i           (reset_i),
		.DRAM_get_i        (DRAM_get_i),
		.cnt_k_i           (cnt_k_i),
		.cnt_l_i           (cnt_l_i),
		.head_ctx_i        (head_ctx),
		.queue_count_i     (queue_count),
		.pop_o             (pop),
		.push_o            (push),
		.push_ctx_o        (push_ctx),
		.new_read_valid_i  (new_read_valid),
		.new_ctx_i         (new_ctx),
		.new_read_o        (new_read),
		.lookup_read_num_o (lookup_read_num),
		.lookup_pos_o      (lookup_pos),
		.lookup_base_i     (lookup_base),
		.lookup_len_i      (lookup_len),
		.c_table_i         (c_table),
		.DRAM_valid_o      (DRAM_valid_o),
		.addr_k_o          (addr_k_o),
		.addr_l_o          (addr_l_o),
		.DRAM_read_num_o   (DRAM_read_num_o),
		.result_valid_o    (result_valid),
		.result_o          (result)
	);

	result_buffer result_buffer_i (
		.clk_32ui_i       (clk_32ui_i),
		.reset_i          (reset_i),
		.batch_size_i     (batch_size_i),
		.result_valid_i   (result_valid),
		.result_i         (result),
		.output_request_o (output_request_o),
		.output_permit_i  (output_permit_i),
		.output_data_o    (output_data_o),
		.output_valid_o   (output_valid_o),
		.output_finish_o  (output_finish_o)
	);

endmodule

// File: run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
	--top-module smem_tb --Mdir "$OBJ" -o smem_sim -f all.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"$OBJ/smem_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Regression failed" "$LOG"; then
	exit 1
fi

exit 0

// File: verification/smem_asserts.sv
`timescale 1ns/10ps

module smem_asserts #(
	parameter int CNT_W = $clog2(smem_pkg::QUEUE_DEPTH + 1)
) (
	input logic                          clk_i,
	input logic                          reset_i,
	input logic                          dram_get_i,
	input logic [CNT_W-1:0]              queue_count_i,
	input logic                          permit_i,
	input logic                          output_valid_i,
	input logic                          dram_valid_i,
	input logic [smem_pkg::IV_WIDTH-1:0] addr_k_i,
	input logic [smem_pkg::IV_WIDTH-1:0] addr_l_i
);

	// ----------------------------------------
	// protocol properties
	// ----------------------------------------
	a_get_has_ctx: assert property (@(posedge clk_i) disable iff (reset_i)
		dram_get_i |-> queue_count_i != '0)
		else $error("memory response with an empty context queue");

	a_valid_after_permit: assert property (@(posedge clk_i) disable iff (reset_i)
		output_valid_i |-> $past(permit_i))
		else $error("output valid without a permit in the cycle before");

	a_req_nonempty: assert property (@(posedge clk_i) disable iff (reset_i)
		dram_valid_i |-> addr_k_i < addr_l_i) // empty intervals never go to memory
		else $error("memory request with an empty interval");

endmodule

bind smem_top smem_asserts #(.CNT_W($clog2(QUEUE_DEPTH + 1))) smem_asserts_i (
	.clk_i          (clk_32ui_i),
	.reset_i        (reset_i),
	.dram_get_i     (DRAM_get_i),
	.queue_count_i  (queue_count),
	.permit_i       (output_permit_i),
	.output_valid_i (output_valid_o),
	.dram_valid_i   (DRAM_valid_o),
	.addr_k_i       (addr_k_o),
	.addr_l_i       (addr_l_o)
);

// File: verification/smem_tb.sv
`timescale 1ns/10ps

module smem_tb;
	import smem_pkg::*;

	localparam int BATCH    = 20;
	localparam int TEXT_LEN = 256;

	// one outstanding memory request
	typedef struct packed {
		logic [READ_NUM_WIDTH-1:0] rn;
		logic [IV_WIDTH-1:0]       k;
		logic [IV_WIDTH-1:0]       l;
		logic [31:0]               due; // cycle of the response
	} req_t;

	logic                      clk;
	logic                      reset;
	logic                      load_valid;
	load_line_t                load_data;
	logic [POS_WIDTH-1:0]      batch_size;
	logic                      load_done;
	logic                      dram_valid;
	logic [IV_WIDTH-1:0]       addr_k;
	logic [IV_WIDTH-1:0]       addr_l;
	logic [READ_NUM_WIDTH-1:0] dram_read_num;
	logic                      dram_get;
	occ_counts_t               cnt_k;
	occ_counts_t               cnt_l;
	logic                      out_request;
	logic                      out_permit;
	logic [CL-1:0]             out_data;
	logic                      out_valid;
	logic                      out_finish;

	// ----------------------------------------
	// stimulus and model state
	// ----------------------------------------
	logic [15:0]  lfsr;
	base_t        text [TEXT_LEN];
	int unsigned  occ_tab [4][TEXT_LEN+1]; // base count before each index
	int unsigned  c_tab [4];
	int unsigned  rd_len [BATCH];
	base_t        rd_bases [BATCH][MAX_BASES];
	int unsigned  m_pos [BATCH];
	int unsigned  m_k [BATCH];
	int unsigned  m_l [BATCH];
	bit           m_wait [BATCH];          // model expects a request
	bit           exp_done [BATCH];
	result_t      exp_res [BATCH];
	bit           seen [BATCH];
	req_t         pend [$];
	int           ready_q [$];             // cycles when results reach the output buffer

	bit           running;
	bit           gen_done;
	bit           done_seen;
	bit           req_model;               // model of the output request level
	int           cyc;
	int           n_out;
	int           n_ready;
	int           max_pend;
	int           overlap_cnt;
	int           empty_cnt;
	int           total_bases;
	int           limit;
	int           checks;
	int           errors;

	smem_top smem_top_i (
		.clk_32ui_i       (clk),
		.reset_i          (reset),
		.load_valid_i     (load_valid),
		.load_data_i      (load_data),
		.batch_size_i     (batch_size),
		.read_load_done_o (load_done),
		.DRAM_valid_o     (dram_valid),
		.addr_k_o         (addr_k),
		.addr_l_o         (addr_l),
		.DRAM_read_num_o  (dram_read_num),
		.DRAM_get_i       (dram_get),
		.cnt_k_i          (cnt_k),
		.cnt_l_i          (cnt_l),
		.output_request_o (out_request),
		.output_permit_i  (out_permit),
		.output_data_o    (out_data),
		.output_valid_o   (out_valid),
		.output_finish_o  (out_finish)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic int unsigned rand_bits(input int n);
		int unsigned v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = (v << 1) | lfsr[0];
		end
		return v;
	endfunction

	task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %0t: %s (got %0h, expected %0h)", $time, msg, got, exp);
		end
	endtask

	function automatic occ_counts_t occ_at(input logic [IV_WIDTH-1:0] addr);
		occ_counts_t o;
		int a;
		a = (addr > TEXT_LEN) ? TEXT_LEN : int'(addr); // keep a bad address in range
		o.a = occ_tab[0][a];
		o.c = occ_tab[1][a];
		o.g = occ_tab[2][a];
		o.t = occ_tab[3][a];
		return o;
	endfunction

	function automatic load_line_t make_param_line();
		load_line_t ln;
		ln = '0;
		ln.param.line.seq_len = TEXT_LEN;
		for (int c = 0; c < 4; c++)
			ln.param.line.c_table[c] = c_tab[c];
		return ln;
	endfunction

	function automatic load_line_t encode_read(input int r);
		load_line_t ln;
		ln = '0;
		ln.rd.line.len = POS_WIDTH'(rd_len[r]);
		for (int j = 0; j < MAX_BASES; j++)
			ln.rd.line.bases[j] = rd_bases[r][j];
		return ln;
	endfunction

	// one interval step for read r, as the response carries it
	task automatic advance_model(input int r);
		base_t b;
		int unsigned nk;
		int unsigned nl;
		b  = rd_bases[r][m_pos[r]];
		nk = c_tab[b] + occ_tab[b][m_k[r]];
		nl = c_tab[b] + occ_tab[b][m_l[r]];
		if (nl <= nk) begin
			exp_res[r] = '{read_num: r, match_len: m_pos[r], k: m_k[r], l: m_l[r]};
			exp_done[r] = 1'b1;
			empty_cnt++;
		end else if (m_pos[r] + 1 == rd_len[r]) begin
			exp_res[r] = '{read_num: r, match_len: rd_len[r], k: nk, l: nl};
			exp_done[r] = 1'b1;
		end else begin
			m_pos[r]++;
			m_k[r]    = nk;
			m_l[r]    = nl;
			m_wait[r] = 1'b1;
		end
	endtask

	// ----------------------------------------
	// memory responder and output checker
	// ----------------------------------------
	always @(negedge clk) begin
		req_t    req;
		result_t res;
		int      rn;
		if (running) begin
			cyc++;
			while (ready_q.size() > 0 && ready_q[0] <= cyc) begin
				void'(ready_q.pop_front());
				n_ready++;
			end
			check_value(out_finish, n_out >= BATCH, "output finish level");
			check_value(out_valid, out_permit && req_model, "output valid after a permit");
			if (done_seen)
				check_value(load_done, 1'b1, "load done stays high");
			if (load_done)
				done_seen = 1'b1;

			if (dram_valid) begin
				rn = int'(dram_read_num);
				check_value(rn < BATCH, 1'b1, "request read number in range");
				if (rn < BATCH) begin
					check_value(m_wait[rn], 1'b1, $sformatf("read %0d not waiting", rn));
					check_value(addr_k, m_k[rn], $sformatf("read %0d request k", rn));
					check_value(addr_l, m_l[rn], $sformatf("read %0d request l", rn));
					m_wait[rn] = 1'b0;
					foreach (pend[i])
						if (int'(pend[i].rn) != rn)
							overlap_cnt++;
					req.rn  = dram_read_num;
					req.k   = addr_k;
					req.l   = addr_l;
					req.due = cyc + (rand_bits(3) % 6) + 1; // 1 to 6 cycles
					pend.push_back(req);
					if (pend.size() > max_pend)
						max_pend = pend.size();
				end
			end

			if (out_valid) begin
				res = out_data[$bits(result_t)-1:0];
				check_value((out_data >> $bits(result_t)) == '0, 1'b1, "output padding");
				rn = int'(res.read_num);
				if (rn < BATCH) begin
					check_value(seen[rn], 1'b0, $sformatf("read %0d output twice", rn));
					check_value(exp_done[rn], 1'b1, $sformatf("read %0d output early", rn));
					check_value(res.match_len, exp_res[rn].match_len,
						$sformatf("read %0d match_len", rn));
					check_value(res.k, exp_res[rn].k, $sformatf("read %0d k", rn));
					check_value(res.l, exp_res[rn].l, $sformatf("read %0d l", rn));
					seen[rn] = 1'b1;
				end else begin
					check_value(rn, 0, "output read number out of range");
				end
				n_out++;
			end

			// buffer holds the results that arrived and were not sent yet
			check_value(out_request, n_ready > n_out, "output request level");
			req_model = n_ready > n_out;

			// responses leave in request order
			dram_get = 1'b0;
			if (pend.size() > 0 && pend[0].due <= cyc) begin
				req      = pend.pop_front();
				dram_get = 1'b1;
				cnt_k    = occ_at(req.k);
				cnt_l    = occ_at(req.l);
				advance_model(int'(req.rn));
				if (exp_done[int'(req.rn)])
					ready_q.push_back(cyc + 3); // result written into the buffer
			end
			out_permit = rand_bits(1) != 0;
		end
	end

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		int unsigned start;
		reset      = 1'b1;
		load_valid = 1'b0;
		load_data  = '0;
		batch_size = POS_WIDTH'(BATCH);
		dram_get   = 1'b0;
		cnt_k      = '0;
		cnt_l      = '0;
		out_permit = 1'b0;

		lfsr = 16'd36;
		for (int i = 0; i < TEXT_LEN; i++)
			text[i] = base_t'(rand_bits(2));
		for (int c = 0; c < 4; c++) begin
			occ_tab[c][0] = 0;
			for (int i = 0; i < TEXT_LEN; i++)
				occ_tab[c][i+1] = occ_tab[c][i] + ((text[i] == base_t'(c)) ? 1 : 0);
		end
		c_tab[0] = 0;
		for (int c = 1; c < 4; c++)
			c_tab[c] = c_tab[c-1] + occ_tab[c-1][TEXT_LEN];
		for (int r = 0; r < BATCH; r++) begin
			rd_len[r] = rand_bits(6) + 1;
			start     = rand_bits(8);
			for (int j = 0; j < MAX_BASES; j++) begin
				if (j >= rd_len[r])
					rd_bases[r][j] = '0;
				else if (r % 2 == 0)
					rd_bases[r][j] = text[(start + j) % TEXT_LEN]; // long match
				else
					rd_bases[r][j] = base_t'(rand_bits(2));
			end
			total_bases += rd_len[r];
			m_pos[r]  = 0;
			m_k[r]    = 0;
			m_l[r]    = TEXT_LEN; // full interval
			m_wait[r] = 1'b1;
		end
		limit    = 200 * total_bases + 1000;
		gen_done = 1'b1;

		repeat (8) @(posedge clk);
		running = 1'b1;
		@(negedge clk);
		check_value(load_done, 1'b0, "load done after reset");
		check_value(dram_valid, 1'b0, "memory request after reset");
		check_value(out_request, 1'b0, "output request after reset");
		check_value(out_valid, 1'b0, "output valid after reset");
		check_value(out_finish, 1'b0, "output finish after reset");
		reset      = 1'b0;
		load_valid = 1'b1;
		load_data  = make_param_line();
		for (int r = 0; r < BATCH; r++) begin
			@(negedge clk);
			check_value(load_done, 1'b0, "load done before the last line");
			load_data = encode_read(r);
		end
		@(negedge clk);
		load_valid = 1'b0;
		load_data  = '0;
		check_value(load_done, 1'b1, "load done after the last line");

		while (n_out < BATCH)
			@(negedge clk);
		repeat (20) @(negedge clk); // catch late duplicates
		#1;

		check_value(n_out, BATCH, "output line count");
		check_value(out_finish, 1'b1, "finish after the last line");
		check_value(pend.size(), 0, "requests left without a response");
		check_value(max_pend > 1, 1'b1, "several reads in flight");
		check_value(overlap_cnt > 0, 1'b1, "requests of different reads interleaved");
		check_value(empty_cnt > 0, 1'b1, "reads ending on an empty interval");
		for (int r = 0; r < BATCH; r++)
			check_value(seen[r], 1'b1, $sformatf("read %0d has an output", r));

		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// run length scales with the number of bases
	initial begin
		wait (gen_done);
		repeat (limit) @(posedge clk);
		$display("Timeout: outputs did not complete within %0d cycles", limit);
		$display("Checks %0d, errors %0d", checks, errors);
		$display("Regression failed");
		$finish;
	end

endmodule
